// File: ciPkg.sv
package ciPkg;

  // Data path widths
  localparam int ciWordW     = 32;
  localparam int ciNumberW   = 8;
  localparam int resetCountW = 5;   // Top bit marks reset release
  localparam int delayCountW = 40;  // Operand A times cycles per microsecond

  // Custom-instruction numbers as seen on the CPU side
  typedef enum logic [ciNumberW-1:0] {
    ciSwapByte = 8'd1,
    ciCpuFreq  = 8'd4,
    ciDelay    = 8'd6
  } ciOpcodeE;

  // Operands are valid in the start cycle only
  typedef struct packed {
    ciOpcodeE             number;
    logic [ciWordW-1:0]   operandA;
    logic [ciWordW-1:0]   operandB;
  } ciRequestT;

  // One bit per execute unit, already qualified with start and ready
  typedef struct packed {
    logic swapByte;
    logic cpuFreq;
    logic delay;
  } ciSelectT;

  typedef struct packed {
    logic                 done;
    logic [ciWordW-1:0]   result;  // Zero unless done
  } ciResponseT;

endpackage

// File: resetSequencer.sv
module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReady
);

  localparam logic [ciPkg::resetCountW-1:0] countOne = {{(ciPkg::resetCountW-1){1'b0}}, 1'b1};

  logic [ciPkg::resetCountW-1:0] s_resetCountReg;

  // Saturates once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (!s_resetCountReg[ciPkg::resetCountW-1]) begin
      s_resetCountReg <= s_resetCountReg + countOne;
    end
  end

  assign systemReady = s_resetCountReg[ciPkg::resetCountW-1];

  // Ready may only drop through loss of lock
  readyHolds: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    systemReady |=> systemReady
  ) else $error("systemReady dropped while PLL locked");

endmodule

// File: ciDecode.sv
module ciDecode (
  input  logic             s_systemClock,
  input  logic             s_pllLocked,
  input  logic             systemReady,
  input  logic             ciStart,
  input  ciPkg::ciRequestT ciRequest,
  output ciPkg::ciSelectT  ciSelect
);

  ciPkg::ciOpcodeE s_opcode;
  logic            s_qualifiedStart;

  assign s_opcode         = ciRequest.number;
  assign s_qualifiedStart = ciStart & systemReady;  // CPU held in reset until ready

  always_comb begin
    ciSelect = '0;
    if (s_qualifiedStart) begin
      case (s_opcode)
        ciPkg::ciSwapByte: begin
          ciSelect.swapByte = 1'b1;
        end
        ciPkg::ciCpuFreq: begin
          ciSelect.cpuFreq = 1'b1;
        end
        ciPkg::ciDelay: begin
          ciSelect.delay = 1'b1;
        end
        default: begin
          // Unknown numbers never answer
          ciSelect = '0;
        end
      endcase
    end
  end

  // Units share one result path, so only one may start
  selectOneHot: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    $onehot0(ciSelect)
  ) else $error("more than one execute unit selected");

endmodule

// File: singleCycleUnit.sv
module singleCycleUnit #(
  parameter int clockFrequencyInHz = 125000000
) (
  input  logic              s_systemClock,
  input  logic              s_pllLocked,
  input  ciPkg::ciSelectT   ciSelect,
  input  ciPkg::ciRequestT  ciRequest,
  output ciPkg::ciResponseT swapResponse
);

  // Reported as is, no measurement
  localparam logic [ciPkg::ciWordW-1:0] cpuFrequency = clockFrequencyInHz;

  logic [ciPkg::ciWordW-1:0] s_operandA;
  logic [ciPkg::ciWordW-1:0] s_fullReverse;
  logic [ciPkg::ciWordW-1:0] s_halfSwap;
  logic [ciPkg::ciWordW-1:0] s_swapValue;
  logic [ciPkg::ciWordW-1:0] s_swapResult;
  logic [ciPkg::ciWordW-1:0] s_freqResult;

  assign s_operandA    = ciRequest.operandA;
  assign s_fullReverse = {s_operandA[7:0], s_operandA[15:8],
                          s_operandA[23:16], s_operandA[31:24]};
  assign s_halfSwap    = {s_operandA[23:16], s_operandA[31:24],
                          s_operandA[7:0], s_operandA[15:8]};

  // Operand B bit 0 picks the full reversal
  assign s_swapValue = ciRequest.operandB[0] ? s_fullReverse : s_halfSwap;

  assign s_swapResult = ciSelect.swapByte ? s_swapValue : '0;
  assign s_freqResult = ciSelect.cpuFreq ? cpuFrequency : '0;

  assign swapResponse.done   = ciSelect.swapByte | ciSelect.cpuFreq;
  assign swapResponse.result = s_swapResult | s_freqResult;

  // Zero latency answer must track its select
  doneNeedsSelect: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    swapResponse.done |-> (ciSelect.swapByte || ciSelect.cpuFreq)
  ) else $error("single cycle unit answered without a select");

endmodule

// File: delayUnit.sv
module delayUnit #(
  parameter int clockFrequencyInHz = 125000000
) (
  input  logic              s_systemClock,
  input  logic              s_pllLocked,
  input  ciPkg::ciSelectT   ciSelect,
  input  ciPkg::ciRequestT  ciRequest,
  output ciPkg::ciResponseT delayResponse
);

  localparam int padW = ciPkg::delayCountW - ciPkg::ciWordW;

  localparam logic [ciPkg::ciWordW-1:0] cyclesPerMicro = clockFrequencyInHz / 1000000;
  localparam logic [ciPkg::delayCountW-1:0] countOne =
    {{(ciPkg::delayCountW-1){1'b0}}, 1'b1};

  logic [ciPkg::delayCountW-1:0] s_operandWide;
  logic [ciPkg::delayCountW-1:0] s_cyclesWide;
  logic [ciPkg::delayCountW-1:0] s_loadCount;
  logic [ciPkg::delayCountW-1:0] s_countReg;
  logic                          s_busy;
  logic                          s_zeroDelay;
  logic                          s_countExpires;

  assign s_operandWide = {{padW{1'b0}}, ciRequest.operandA};
  assign s_cyclesWide  = {{padW{1'b0}}, cyclesPerMicro};
  assign s_loadCount   = s_operandWide * s_cyclesWide;

  assign s_busy = |s_countReg;

  // Loaded on the select edge, then one step per cycle
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_countReg <= '0;
    end else if (ciSelect.delay) begin
      s_countReg <= s_loadCount;
    end else if (s_busy) begin
      s_countReg <= s_countReg - countOne;
    end
  end

  assign s_zeroDelay    = ciSelect.delay && (s_loadCount == '0);  // Answer right away
  assign s_countExpires = (s_countReg == countOne);              // Count hits zero on this edge

  assign delayResponse.done   = s_zeroDelay | s_countExpires;
  assign delayResponse.result = '0;

  // CPU stalls on a running delay, so nothing may start meanwhile
  noStartWhileBusy: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    (|ciSelect) |-> !s_busy
  ) else $error("custom instruction started while delay busy");

endmodule

// File: ciCollect.sv
module ciCollect (
  input  logic              s_systemClock,
  input  logic              s_pllLocked,
  input  ciPkg::ciResponseT swapResponse,
  input  ciPkg::ciResponseT delayResponse,
  output ciPkg::ciResponseT ciResponse
);

  ciPkg::ciResponseT s_combined;

  // Idle units drive zero, so OR acts as the result bus
  assign s_combined = swapResponse | delayResponse;

  // Output register for timing toward the CPU
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      ciResponse <= '0;
    end else begin
      ciResponse <= s_combined;
    end
  end

  unitsExclusive: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !(swapResponse.done && delayResponse.done)
  ) else $error("two execute units answered together");

endmodule

// File: ciSubsystem.sv
module ciSubsystem #(
  parameter int clockFrequencyInHz = 125000000
) (
  input  logic              s_systemClock,
  input  logic              s_pllLocked,
  input  logic              ciStart,
  input  ciPkg::ciRequestT  ciRequest,
  output logic              systemReady,
  output ciPkg::ciResponseT ciResponse
);

  ciPkg::ciSelectT   s_ciSelect;
  ciPkg::ciResponseT s_swapResponse;
  ciPkg::ciResponseT s_delayResponse;

  resetSequencer u_resetSequencer (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReady   (systemReady)
  );

  // Starts before ready are dropped here
  ciDecode u_ciDecode (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReady   (systemReady),
    .ciStart       (ciStart),
    .ciRequest     (ciRequest),
    .ciSelect      (s_ciSelect)
  );

  singleCycleUnit #(
    .clockFrequencyInHz (clockFrequencyInHz)
  ) u_singleCycleUnit (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciSelect      (s_ciSelect),
    .ciRequest     (ciRequest),
    .swapResponse  (s_swapResponse)
  );

  delayUnit #(
    .clockFrequencyInHz (clockFrequencyInHz)
  ) u_delayUnit (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciSelect      (s_ciSelect),
    .ciRequest     (ciRequest),
    .delayResponse (s_delayResponse)
  );

  ciCollect u_ciCollect (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .swapResponse  (s_swapResponse),
    .delayResponse (s_delayResponse),
    .ciResponse    (ciResponse)
  );

endmodule

// File: tbCiSubsystem.sv
module tbCiSubsystem;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clockHz        = 125000000;
  localparam int cyclesPerMicro = clockHz / 1000000;
  localparam int readyEdges     = 16;   // Edges after lock until release
  localparam int resetCycles    = 10;
  localparam int unknownWindow  = 200;  // Cycles an unknown number is watched
  localparam int maxDelayMicro  = 3;

  localparam int numSwaps    = 30;
  localparam int numFreqs    = 10;
  localparam int numDelays   = 20;
  localparam int numUnknowns = 3;

  // Worst case of every test plus reset, ready wait and slack
  localparam int timeoutCycles = resetCycles + readyEdges + 10
                               + numSwaps * 2 + numFreqs * 2
                               + numDelays * (maxDelayMicro * cyclesPerMicro + 2)
                               + numUnknowns * (unknownWindow + 2) + 500;

  logic              s_systemClock;
  logic              s_pllLocked;
  logic              ciStart;
  ciPkg::ciRequestT  ciRequest;
  logic              systemReady;
  ciPkg::ciResponseT ciResponse;

  logic [31:0] lfsrState;
  int          cycleCount = 0;
  int          lockEdges;

  // Expected answer for the request in flight
  logic        pending;
  logic        expectAnswer;
  int          elapsed;
  int          target;
  logic [31:0] expectedResult;

  ciSubsystem #(
    .clockFrequencyInHz (clockHz)
  ) u_dut (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciRequest     (ciRequest),
    .systemReady   (systemReady),
    .ciResponse    (ciResponse)
  );

  always #4 s_systemClock = ~s_systemClock;

  function automatic logic [31:0] stepLfsr(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'hB4BC_D35C;
    end
    return next;
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value     = {value[30:0], lfsrState[0]};
      lfsrState = stepLfsr(lfsrState);
    end
    return value;
  endfunction

  function automatic logic [31:0] reverseBytes(input logic [31:0] value);
    logic [31:0] flipped;
    for (int i = 0; i < 4; i++) begin
      flipped[8*i +: 8] = value[8*(3-i) +: 8];
    end
    return flipped;
  endfunction

  function automatic logic [31:0] swapHalfBytes(input logic [31:0] value);
    logic [31:0] swapped;
    for (int h = 0; h < 2; h++) begin
      swapped[16*h +: 8]     = value[16*h + 8 +: 8];
      swapped[16*h + 8 +: 8] = value[16*h +: 8];
    end
    return swapped;
  endfunction

  function automatic logic isKnownNumber(input logic [7:0] number);
    return number == ciPkg::ciSwapByte || number == ciPkg::ciCpuFreq ||
           number == ciPkg::ciDelay;
  endfunction

  task automatic reportMismatch(input string message);
    $display("MISMATCH at %0t ns: %s", $time, message);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // Saturating count of edges since lock
  always @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockEdges <= 0;
    end else if (lockEdges < 1000) begin
      lockEdges <= lockEdges + 1;
    end
  end

  always @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      pending        <= 1'b0;
      expectAnswer   <= 1'b0;
      elapsed        <= 0;
      target         <= 0;
      expectedResult <= '0;
    end else if (ciStart && lockEdges >= readyEdges) begin
      pending <= 1'b1;
      elapsed <= 1;
      case (ciRequest.number)
        ciPkg::ciSwapByte: begin
          expectAnswer   <= 1'b1;
          target         <= 1;
          expectedResult <= ciRequest.operandB[0] ? reverseBytes(ciRequest.operandA)
                                                  : swapHalfBytes(ciRequest.operandA);
        end
        ciPkg::ciCpuFreq: begin
          expectAnswer   <= 1'b1;
          target         <= 1;
          expectedResult <= 32'(clockHz);
        end
        ciPkg::ciDelay: begin
          expectAnswer   <= 1'b1;
          target         <= int'(ciRequest.operandA) * cyclesPerMicro + 1;
          expectedResult <= '0;
        end
        default: begin
          expectAnswer   <= 1'b0;  // Must stay silent
          target         <= unknownWindow;
          expectedResult <= '0;
        end
      endcase
    end else if (pending) begin
      elapsed <= elapsed + 1;
      if (ciResponse.done || (!expectAnswer && elapsed >= target)) begin
        pending <= 1'b0;
      end
    end
  end

  always @(posedge s_systemClock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: test did not finish within %0d cycles", timeoutCycles);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  readyTiming: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    systemReady == (lockEdges >= readyEdges)
  ) else reportMismatch("systemReady does not follow the lock edge count");

  noStrayDone: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !pending |-> !ciResponse.done
  ) else reportMismatch("done without an accepted instruction");

  answerExpected: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    (pending && ciResponse.done) |-> expectAnswer
  ) else reportMismatch("unknown instruction number answered");

  answerOnTime: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    (pending && ciResponse.done) |-> elapsed == target
  ) else reportMismatch("done arrived at the wrong cycle");

  answerResult: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    (pending && ciResponse.done) |-> ciResponse.result == expectedResult
  ) else reportMismatch("wrong result value");

  answerNotLate: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    (pending && expectAnswer && !ciResponse.done) |-> elapsed < target
  ) else reportMismatch("done missing at expected cycle");

  resultIdleZero: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !ciResponse.done |-> ciResponse.result == '0
  ) else reportMismatch("result nonzero while done low");

  donePulse: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    ciResponse.done |=> !ciResponse.done
  ) else reportMismatch("done longer than one cycle");

  task automatic issueRequest(input ciPkg::ciRequestT request);
    ciRequest <= request;
    ciStart   <= 1'b1;
    @(posedge s_systemClock);
    ciStart   <= 1'b0;
  endtask

  task automatic waitForDone();
    do begin
      @(posedge s_systemClock);
    end while (!ciResponse.done);
  endtask

  task automatic runInstruction(input logic [7:0] number, input logic [31:0] operandA,
                                input logic [31:0] operandB);
    ciPkg::ciRequestT request;
    request.number   = ciPkg::ciOpcodeE'(number);
    request.operandA = operandA;
    request.operandB = operandB;
    issueRequest(request);
    if (isKnownNumber(number)) begin
      waitForDone();
    end else begin
      repeat (unknownWindow + 1) @(posedge s_systemClock);
    end
  endtask

  initial begin
    logic [31:0]      operandA;
    logic [31:0]      operandB;
    logic [7:0]       number;
    ciPkg::ciRequestT earlyRequest;

    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    ciStart       = 1'b0;
    ciRequest     = '0;
    lfsrState     = 32'h3989_4beb;

    repeat (resetCycles) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;

    // Dropped while still held in reset
    repeat (3) @(posedge s_systemClock);
    earlyRequest.number   = ciPkg::ciSwapByte;
    earlyRequest.operandA = takeBits(32);
    earlyRequest.operandB = takeBits(32);
    issueRequest(earlyRequest);
    while (!systemReady) begin
      @(posedge s_systemClock);
    end

    for (int i = 0; i < numSwaps; i++) begin
      operandA    = takeBits(32);
      operandB    = takeBits(32);
      operandB[0] = (i % 2 == 1);  // Both swap modes
      runInstruction(ciPkg::ciSwapByte, operandA, operandB);
    end

    for (int i = 0; i < numFreqs; i++) begin
      runInstruction(ciPkg::ciCpuFreq, takeBits(32), takeBits(32));
    end

    for (int i = 0; i < numDelays; i++) begin
      runInstruction(ciPkg::ciDelay, takeBits(2), takeBits(32));
    end

    for (int i = 0; i < numUnknowns; i++) begin
      do begin
        number = 8'(takeBits(8));
      end while (isKnownNumber(number));
      runInstruction(number, takeBits(32), takeBits(32));
    end

    repeat (4) @(posedge s_systemClock);
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: src.f
ciPkg.sv
resetSequencer.sv
ciDecode.sv
singleCycleUnit.sv
delayUnit.sv
ciCollect.sv
ciSubsystem.sv
tbCiSubsystem.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tbCiSubsystem
FILELIST  = src.f
BUILDDIR  = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee /dev/stderr | grep "TB PASSED"

clean:
	rm -rf $(BUILDDIR)
